//--- verilog/mfp_pkg.sv
package mfp_pkg;

    // bus
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;

    // board widths
    localparam int SW_WIDTH        = 10;
    localparam int KEY_WIDTH       = 4;
    localparam int RED_LED_WIDTH   = 18;
    localparam int GREEN_LED_WIDTH = 9;

    // register offsets, only bits 4:2 are decoded
    localparam haddr_t ADDR_RED_LEDS   = 32'h00;
    localparam haddr_t ADDR_GREEN_LEDS = 32'h04;
    localparam haddr_t ADDR_SWITCHES   = 32'h08;
    localparam haddr_t ADDR_BUTTONS    = 32'h0C;
    localparam haddr_t ADDR_TICKS      = 32'h10;

    typedef logic [2:0] reg_sel_t;

    // debounce
    localparam int DEBOUNCE_CYCLES    = 8;
    localparam int DEBOUNCE_CNT_WIDTH = $clog2(DEBOUNCE_CYCLES);

    typedef logic [DEBOUNCE_CNT_WIDTH-1:0] db_count_t;

    // divider periods in clock cycles
    localparam int DIV_MID       = 16;
    localparam int DIV_SLOW      = 64;
    localparam int DIV_CNT_WIDTH = $clog2(DIV_SLOW);

    typedef logic [DIV_CNT_WIDTH-1:0] div_count_t;

    typedef enum logic [1:0] {
        RATE_FAST,
        RATE_MID,
        RATE_SLOW
    } tick_rate_t;

endpackage

//--- verilog/mfp_switch_debouncer.sv
module mfp_switch_debouncer
    import mfp_pkg::*;
#(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] sw_in,
    output logic [WIDTH-1:0] sw_out
);

    logic [WIDTH-1:0] sync_1;
    logic [WIDTH-1:0] sync_2;
    db_count_t        count [WIDTH];

    // two-stage synchroniser for the asynchronous board inputs
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= sw_in;
            sync_2 <= sync_1;
        end
    end

    // each bit has its own stability counter
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_out <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_2[i] == sw_out[i]) begin
                    // a bounce back to the old level restarts the count
                    count[i] <= '0;
                end else if (count[i] == db_count_t'(DEBOUNCE_CYCLES - 1)) begin
                    sw_out[i] <= sync_2[i];
                    count[i]  <= '0;
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/mfp_tick_divider.sv
module mfp_tick_divider
    import mfp_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sel_lo,
    input  logic sel_mid,
    output logic tick
);

    tick_rate_t rate;
    tick_rate_t rate_sel;
    div_count_t count;
    div_count_t count_last;

    // sel_lo has priority and picks the slowest rate
    always_comb begin
        if (sel_lo) begin
            rate_sel = RATE_SLOW;
        end else if (sel_mid) begin
            rate_sel = RATE_MID;
        end else begin
            rate_sel = RATE_FAST;
        end
    end

    always_comb begin
        if (rate == RATE_SLOW) begin
            count_last = div_count_t'(DIV_SLOW - 1);
        end else begin
            count_last = div_count_t'(DIV_MID - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rate  <= RATE_FAST;
            count <= '0;
            tick  <= 1'b0;
        end else if (rate_sel != rate) begin
            // new rate starts a fresh period
            rate  <= rate_sel;
            count <= '0;
            tick  <= 1'b0;
        end else if (rate == RATE_FAST) begin
            count <= '0;
            tick  <= 1'b1;
        end else if (count == count_last) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- verilog/mfp_seven_segment_digit.sv
module mfp_seven_segment_digit (
    input  logic [3:0] digit,
    output logic [6:0] seg
);

    // segments are gfedcba, a lit segment is driven low
    always_comb begin
        case (digit)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b0000011;
            4'hc:    seg = 7'b1000110;
            4'hd:    seg = 7'b0100001;
            4'he:    seg = 7'b0000110;
            4'hf:    seg = 7'b0001110;
            default: seg = 7'b1111111;
        endcase
    end

endmodule

//--- verilog/mfp_gpio_slave.sv
module mfp_gpio_slave
    import mfp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       hsel,
    input  logic                       hwrite,
    input  haddr_t                     haddr,
    input  hdata_t                     hwdata,
    output hdata_t                     hrdata,

    input  logic [SW_WIDTH-1:0]        switches,
    input  logic [KEY_WIDTH-1:0]       keys,
    input  logic                       tick,

    output logic [RED_LED_WIDTH-1:0]   red_leds,
    output logic [GREEN_LED_WIDTH-1:0] green_leds
);

    reg_sel_t                reg_sel;
    logic                    wr_en;
    logic                    rd_en;
    logic                    ticks_clear;
    logic [KEY_WIDTH-1:0]    keys_pressed;
    hdata_t                  tick_count;
    hdata_t                  rdata_next;

    assign reg_sel = haddr[4:2];
    assign wr_en   = hsel & hwrite;
    assign rd_en   = hsel & ~hwrite;

    // any write to the tick offset clears the counter, whatever the data
    assign ticks_clear = wr_en && (reg_sel == ADDR_TICKS[4:2]);

    // board keys are active low
    assign keys_pressed = ~keys;

    always_ff @(posedge clk) begin
        if (rst) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                ADDR_RED_LEDS[4:2]: begin
                    red_leds <= hwdata[RED_LED_WIDTH-1:0];
                end
                ADDR_GREEN_LEDS[4:2]: begin
                    green_leds <= hwdata[GREEN_LED_WIDTH-1:0];
                end
                default: begin
                    // read-only or unmapped
                end
            endcase
        end
    end

    // clear wins over a tick in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tick_count <= '0;
        end else if (ticks_clear) begin
            tick_count <= '0;
        end else if (tick) begin
            tick_count <= tick_count + 1'b1;
        end
    end

    always_comb begin
        case (reg_sel)
            ADDR_RED_LEDS[4:2]:   rdata_next = hdata_t'(red_leds);
            ADDR_GREEN_LEDS[4:2]: rdata_next = hdata_t'(green_leds);
            ADDR_SWITCHES[4:2]:   rdata_next = hdata_t'(switches);
            ADDR_BUTTONS[4:2]:    rdata_next = hdata_t'(keys_pressed);
            ADDR_TICKS[4:2]:      rdata_next = tick_count;
            default:              rdata_next = '0;
        endcase
    end

    // read data comes one cycle after the transfer and holds until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            hrdata <= '0;
        end else if (rd_en) begin
            hrdata <= rdata_next;
        end
    end

endmodule

//--- verilog/de1_io.sv
module de1_io
    import mfp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic [SW_WIDTH-1:0]        sw,
    input  logic [KEY_WIDTH-1:0]       key,

    input  logic                       hsel,
    input  logic                       hwrite,
    input  haddr_t                     haddr,
    input  hdata_t                     hwdata,
    output hdata_t                     hrdata,

    output logic [RED_LED_WIDTH-1:0]   ledr,
    output logic [GREEN_LED_WIDTH-1:0] ledg,

    output logic [6:0]                 hex0,
    output logic [6:0]                 hex1,
    output logic [6:0]                 hex2,
    output logic [6:0]                 hex3
);

    logic [SW_WIDTH-1:0]  sw_clean;
    logic [KEY_WIDTH-1:0] key_clean;
    logic                 tick;

    mfp_switch_debouncer #(
        .WIDTH (SW_WIDTH)
    ) sw_db (
        .clk    (clk),
        .rst    (rst),
        .sw_in  (sw),
        .sw_out (sw_clean)
    );

    mfp_switch_debouncer #(
        .WIDTH (KEY_WIDTH)
    ) key_db (
        .clk    (clk),
        .rst    (rst),
        .sw_in  (key),
        .sw_out (key_clean)
    );

    // slow-rate enable instead of a divided clock
    mfp_tick_divider tick_div (
        .clk     (clk),
        .rst     (rst),
        .sel_lo  (sw_clean[0]),
        .sel_mid (sw_clean[1]),
        .tick    (tick)
    );

    mfp_gpio_slave gpio (
        .clk        (clk),
        .rst        (rst),
        .hsel       (hsel),
        .hwrite     (hwrite),
        .haddr      (haddr),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .switches   (sw_clean),
        .keys       (key_clean),
        .tick       (tick),
        .red_leds   (ledr),
        .green_leds (ledg)
    );

    // low half of the red LED register on the four digits
    mfp_seven_segment_digit digit_3 (
        .digit (ledr[15:12]),
        .seg   (hex3)
    );

    mfp_seven_segment_digit digit_2 (
        .digit (ledr[11:8]),
        .seg   (hex2)
    );

    mfp_seven_segment_digit digit_1 (
        .digit (ledr[7:4]),
        .seg   (hex1)
    );

    mfp_seven_segment_digit digit_0 (
        .digit (ledr[3:0]),
        .seg   (hex0)
    );

endmodule

//--- tests/de1_io_tb.sv
module de1_io_tb
    import mfp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 16;
    localparam int          SETTLE_CYCLES = 2 + DEBOUNCE_CYCLES + 4;
    localparam int          LED_ROUNDS    = 16;
    localparam int          BOUNCE_ROUNDS = 8;
    localparam int          KEY_ROUNDS    = 4;
    localparam int unsigned SEED          = 32'h9d8e3821;

    localparam hdata_t RED_MASK   = (hdata_t'(1) << RED_LED_WIDTH) - 1;
    localparam hdata_t GREEN_MASK = (hdata_t'(1) << GREEN_LED_WIDTH) - 1;

    // the watchdog allows twice the rough cycle cost of all tests
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * SETTLE_CYCLES + 40
        + LED_ROUNDS * 16 + 80
        + 16 * 6
        + BOUNCE_ROUNDS * (3 * DEBOUNCE_CYCLES + SETTLE_CYCLES + 8)
        + 2 * (SETTLE_CYCLES + 8)
        + (KEY_ROUNDS + 1) * (SETTLE_CYCLES + 8)
        + SETTLE_CYCLES + 48
        + 4 * (SETTLE_CYCLES + 16) + 64 + 10 * DIV_MID + 14 * DIV_SLOW;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

    logic                       clk;
    logic                       rst;
    logic [SW_WIDTH-1:0]        sw;
    logic [KEY_WIDTH-1:0]       key;
    logic                       hsel;
    logic                       hwrite;
    haddr_t                     haddr;
    hdata_t                     hwdata;
    hdata_t                     hrdata;
    logic [RED_LED_WIDTH-1:0]   ledr;
    logic [GREEN_LED_WIDTH-1:0] ledg;
    logic [6:0]                 hex0;
    logic [6:0]                 hex1;
    logic [6:0]                 hex2;
    logic [6:0]                 hex3;

    de1_io de1_io_i (
        .clk    (clk),
        .rst    (rst),
        .sw     (sw),
        .key    (key),
        .hsel   (hsel),
        .hwrite (hwrite),
        .haddr  (haddr),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .ledr   (ledr),
        .ledg   (ledg),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input hdata_t actual, input hdata_t expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    task automatic bus_write(input haddr_t addr, input hdata_t data);
        @(posedge clk);
        hsel   <= 1'b1;
        hwrite <= 1'b1;
        haddr  <= addr;
        hwdata <= data;
        @(posedge clk);
        hsel   <= 1'b0;
        hwrite <= 1'b0;
    endtask

    // read data is valid in the cycle after the hsel cycle
    task automatic bus_read(input haddr_t addr, output hdata_t data);
        @(posedge clk);
        hsel   <= 1'b1;
        hwrite <= 1'b0;
        haddr  <= addr;
        @(posedge clk);
        hsel <= 1'b0;
        @(negedge clk);
        data = hrdata;
    endtask

    task automatic read_and_check(input haddr_t addr, input string name, input hdata_t expected);
        hdata_t data;
        bus_read(addr, data);
        check_value(name, data, expected);
    endtask

    // two tick counter reads whose hsel cycles are exactly gap cycles apart
    task automatic read_tick_pair(input int gap, output hdata_t first, output hdata_t second);
        @(posedge clk);
        hsel   <= 1'b1;
        hwrite <= 1'b0;
        haddr  <= ADDR_TICKS;
        @(posedge clk);
        hsel <= 1'b0;
        @(negedge clk);
        first = hrdata;
        wait_cycles(gap - 1);
        hsel  <= 1'b1;
        haddr <= ADDR_TICKS;
        @(posedge clk);
        hsel <= 1'b0;
        @(negedge clk);
        second = hrdata;
    endtask

    task automatic set_switches(input logic [SW_WIDTH-1:0] value);
        @(posedge clk);
        sw <= value;
        wait_cycles(SETTLE_CYCLES);
    endtask

    // active-low gfedcba glyphs
    function automatic logic [6:0] hex_glyph(input logic [3:0] value);
        case (value)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'ha:    return 7'h08;
            4'hb:    return 7'h03;
            4'hc:    return 7'h46;
            4'hd:    return 7'h21;
            4'he:    return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    // ticks seen in a window that is a whole number of periods
    function automatic int expected_ticks(input logic [SW_WIDTH-1:0] sw_value, input int window);
        tick_rate_t rate;
        if (sw_value[0]) begin
            rate = RATE_SLOW;
        end else if (sw_value[1]) begin
            rate = RATE_MID;
        end else begin
            rate = RATE_FAST;
        end
        case (rate)
            RATE_SLOW: return window / DIV_SLOW;
            RATE_MID:  return window / DIV_MID;
            default:   return window;
        endcase
    endfunction

    task automatic reset_state_test;
        @(negedge clk);
        check_value("hrdata", hrdata, '0);
        // the counter has not seen a tick yet in the first cycle out of reset
        read_and_check(ADDR_TICKS, "ticks", '0);
        read_and_check(ADDR_RED_LEDS, "red_leds", '0);
        read_and_check(ADDR_GREEN_LEDS, "green_leds", '0);
        read_and_check(ADDR_SWITCHES, "switches", '0);
        check_value("ledr", hdata_t'(ledr), '0);
        check_value("ledg", hdata_t'(ledg), '0);
        check_value("hex0", hdata_t'(hex0), hdata_t'(hex_glyph(4'h0)));
        check_value("hex1", hdata_t'(hex1), hdata_t'(hex_glyph(4'h0)));
        check_value("hex2", hdata_t'(hex2), hdata_t'(hex_glyph(4'h0)));
        check_value("hex3", hdata_t'(hex3), hdata_t'(hex_glyph(4'h0)));
        // key debouncer leaves reset at zero, released keys need it to settle
        wait_cycles(SETTLE_CYCLES);
        read_and_check(ADDR_BUTTONS, "buttons", '0);
    endtask

    task automatic led_register_test;
        hdata_t red_value;
        hdata_t green_value;
        for (int i = 0; i < LED_ROUNDS; i++) begin
            red_value   = $urandom;
            green_value = $urandom;
            bus_write(ADDR_RED_LEDS, red_value);
            bus_write(ADDR_GREEN_LEDS, green_value);
            @(negedge clk);
            check_value("ledr", hdata_t'(ledr), red_value & RED_MASK);
            check_value("ledg", hdata_t'(ledg), green_value & GREEN_MASK);
            read_and_check(ADDR_RED_LEDS, "red_leds", red_value & RED_MASK);
            read_and_check(ADDR_GREEN_LEDS, "green_leds", green_value & GREEN_MASK);
        end
        bus_write(ADDR_SWITCHES, $urandom);
        bus_write(ADDR_BUTTONS, $urandom);
        for (int a = 5; a < 8; a++) begin
            bus_write(haddr_t'(a << 2), $urandom);
            read_and_check(haddr_t'(a << 2), "unmapped", '0);
        end
        read_and_check(ADDR_RED_LEDS, "red_leds", red_value & RED_MASK);
        read_and_check(ADDR_GREEN_LEDS, "green_leds", green_value & GREEN_MASK);
        read_and_check(ADDR_SWITCHES, "switches", '0);
        @(negedge clk);
        check_value("ledr", hdata_t'(ledr), red_value & RED_MASK);
        check_value("ledg", hdata_t'(ledg), green_value & GREEN_MASK);
        // address bits above 4 are ignored
        green_value = ~green_value;
        bus_write(haddr_t'(32'h20) | ADDR_GREEN_LEDS, green_value);
        read_and_check(ADDR_GREEN_LEDS, "green_leds", green_value & GREEN_MASK);
        // a write leaves the last read data on hrdata
        bus_write(ADDR_RED_LEDS, red_value);
        @(negedge clk);
        check_value("hrdata", hrdata, green_value & GREEN_MASK);
    endtask

    task automatic seven_segment_test;
        logic [3:0]  n0;
        logic [3:0]  n1;
        logic [3:0]  n2;
        logic [3:0]  n3;
        logic [31:0] r;
        for (int n = 0; n < 16; n++) begin
            n0 = 4'(n);
            n1 = n0 + 4'd1;
            n2 = n0 + 4'd2;
            n3 = n0 + 4'd3;
            r  = $urandom;
            bus_write(ADDR_RED_LEDS, {14'b0, r[17:16], n3, n2, n1, n0});
            @(negedge clk);
            check_value("hex0", hdata_t'(hex0), hdata_t'(hex_glyph(n0)));
            check_value("hex1", hdata_t'(hex1), hdata_t'(hex_glyph(n1)));
            check_value("hex2", hdata_t'(hex2), hdata_t'(hex_glyph(n2)));
            check_value("hex3", hdata_t'(hex3), hdata_t'(hex_glyph(n3)));
        end
    endtask

    task automatic switch_debounce_test;
        logic [31:0]         r;
        logic [SW_WIDTH-1:0] base;
        logic [SW_WIDTH-1:0] glitch;
        int                  width;
        r    = $urandom;
        base = r[SW_WIDTH-1:0];
        set_switches(base);
        read_and_check(ADDR_SWITCHES, "switches", hdata_t'(base));
        for (int i = 0; i < BOUNCE_ROUNDS; i++) begin
            r      = $urandom;
            glitch = base ^ r[SW_WIDTH-1:0];
            // three short pulses with one cycle back at the old level between them
            for (int p = 0; p < 3; p++) begin
                width = 1 + int'($urandom % (DEBOUNCE_CYCLES - 1));
                @(posedge clk);
                sw <= glitch;
                wait_cycles(width);
                sw <= base;
            end
            wait_cycles(SETTLE_CYCLES);
            read_and_check(ADDR_SWITCHES, "switches", hdata_t'(base));
        end
        r = $urandom;
        set_switches(r[SW_WIDTH-1:0]);
        read_and_check(ADDR_SWITCHES, "switches", hdata_t'(r[SW_WIDTH-1:0]));
    endtask

    task automatic key_readback_test;
        logic [31:0]          r;
        logic [KEY_WIDTH-1:0] pressed;
        for (int i = 0; i < KEY_ROUNDS; i++) begin
            r       = $urandom;
            pressed = r[KEY_WIDTH-1:0];
            @(posedge clk);
            key <= ~pressed;
            wait_cycles(SETTLE_CYCLES);
            read_and_check(ADDR_BUTTONS, "buttons", hdata_t'(pressed));
        end
        @(posedge clk);
        key <= '1;
        wait_cycles(SETTLE_CYCLES);
        read_and_check(ADDR_BUTTONS, "buttons", '0);
    endtask

    task automatic tick_clear_test(input int k);
        hdata_t count;
        set_switches('0);
        bus_write(ADDR_TICKS, $urandom);
        wait_cycles(k);
        bus_read(ADDR_TICKS, count);
        // clear wins at the write edge, then one tick per cycle up to the read's hsel edge
        check_value("ticks", count, hdata_t'(k + 1));
    endtask

    task automatic tick_rate_case(input logic [SW_WIDTH-1:0] sw_value, input int window);
        hdata_t first;
        hdata_t second;
        set_switches(sw_value);
        bus_write(ADDR_TICKS, $urandom);
        read_tick_pair(window, first, second);
        check_value("tick_delta", second - first, hdata_t'(expected_ticks(sw_value, window)));
    endtask

    task automatic tick_rate_test;
        int k;
        k = 2 + int'($urandom % 40);
        tick_clear_test(k);
        tick_rate_case('0, k);
        tick_rate_case(SW_WIDTH'(2), 10 * DIV_MID);
        tick_rate_case(SW_WIDTH'(1), 10 * DIV_SLOW);
        // bit 0 wins when both are set
        tick_rate_case(SW_WIDTH'(3), 4 * DIV_SLOW);
    endtask

    initial begin
        void'($urandom(SEED));
        rst    = 1'b1;
        sw     = '0;
        // released keys sit high
        key    = '1;
        hsel   = 1'b0;
        hwrite = 1'b0;
        haddr  = '0;
        hwdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_state_test();
        led_register_test();
        seven_segment_test();
        switch_debounce_test();
        key_readback_test();
        tick_rate_test();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- vlog.f
verilog/mfp_pkg.sv
verilog/mfp_switch_debouncer.sv
verilog/mfp_tick_divider.sv
verilog/mfp_seven_segment_digit.sv
verilog/mfp_gpio_slave.sv
verilog/de1_io.sv
tests/de1_io_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = de1_io_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
